//--- verilog/stm_pkg.sv
`default_nettype none

package stm_pkg;

  localparam int NumSegment = 2;
  localparam int CycleWidth = 13;
  localparam logic [15:0] RepInfinite = 16'hFFFF;

  // one index tick per rising edge of this system-time bit
  localparam int TickBit = 2;

  // ns * 128 >> 5 gives system ticks at 4 per ns
  localparam int EcToSysMul = 128;
  localparam int EcToSysShift = 5;

  typedef enum logic [7:0] {
    TRANSITION_MODE_SYNC_IDX = 8'h00,
    TRANSITION_MODE_SYS_TIME = 8'h01,
    TRANSITION_MODE_GPIO     = 8'h02,
    TRANSITION_MODE_EXT      = 8'hF0
  } transition_mode_t;

  typedef struct packed {
    logic [CycleWidth-1:0] cycle;
    logic [15:0]           rep;
  } seg_cfg_t;

  typedef struct packed {
    logic             req_segment;
    transition_mode_t transition_mode;
    logic [63:0]      transition_value;
  } stm_settings_t;

  typedef struct packed {
    logic stop;
    logic segment;
  } stm_status_t;

  typedef enum logic [3:0] {
    REG_CTRL    = 4'd0,
    REG_TVAL_LO = 4'd1,
    REG_TVAL_HI = 4'd2,
    REG_CYCLE0  = 4'd3,
    REG_REP0    = 4'd4,
    REG_CYCLE1  = 4'd5,
    REG_REP1    = 4'd6,
    REG_STATUS  = 4'd7
  } wb_reg_addr_t;

endpackage

`default_nettype wire

//--- verilog/stm_settings_wb.sv
`default_nettype none

module stm_settings_wb
  import stm_pkg::*;
(
  input  logic          CLK,
  input  logic          rst_n,
  input  logic          cyc,
  input  logic          stb,
  input  logic          we,
  input  wb_reg_addr_t  adr,
  input  logic [31:0]   dat_w,
  output logic [31:0]   dat_r,
  output logic          ack,
  input  stm_status_t   status,
  output stm_settings_t settings,
  output seg_cfg_t      seg_cfg [NumSegment],
  output logic          update
);

  logic        req;
  logic        wr;
  logic [31:0] rd_data;

  // a new request is only taken while ack is low, which gives the idle cycle
  assign req = cyc && stb && !ack;
  assign wr  = req && we;

  always_comb begin
    rd_data = '0;
    case (adr)
      REG_CTRL: begin
        rd_data[0]    = settings.req_segment;
        rd_data[15:8] = settings.transition_mode;
      end
      REG_TVAL_LO: rd_data = settings.transition_value[31:0];
      REG_TVAL_HI: rd_data = settings.transition_value[63:32];
      REG_CYCLE0:  rd_data[CycleWidth-1:0] = seg_cfg[0].cycle;
      REG_REP0:    rd_data[15:0] = seg_cfg[0].rep;
      REG_CYCLE1:  rd_data[CycleWidth-1:0] = seg_cfg[1].cycle;
      REG_REP1:    rd_data[15:0] = seg_cfg[1].rep;
      REG_STATUS:  rd_data[$bits(stm_status_t)-1:0] = status;
      default:     rd_data = '0;
    endcase
  end

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      ack      <= 1'b0;
      update   <= 1'b0;
      dat_r    <= '0;
      settings <= '0;
      seg_cfg  <= '{default: '0};
    end else begin
      ack    <= req;
      update <= wr && (adr == REG_CTRL);
      if (req && !we) begin
        dat_r <= rd_data;
      end
      if (wr) begin
        case (adr)
          REG_CTRL: begin
            settings.req_segment     <= dat_w[0];
            settings.transition_mode <= transition_mode_t'(dat_w[15:8]);
          end
          REG_TVAL_LO: settings.transition_value[31:0] <= dat_w;
          REG_TVAL_HI: settings.transition_value[63:32] <= dat_w;
          REG_CYCLE0:  seg_cfg[0].cycle <= dat_w[CycleWidth-1:0];
          REG_REP0:    seg_cfg[0].rep <= dat_w[15:0];
          REG_CYCLE1:  seg_cfg[1].cycle <= dat_w[CycleWidth-1:0];
          REG_REP1:    seg_cfg[1].rep <= dat_w[15:0];
          default: ;
        endcase
      end
    end
  end

  // the master must hold the strobe until it has seen ack
  assert property (@(posedge CLK) disable iff (!rst_n) ack |-> (cyc && stb));

endmodule

`default_nettype wire

//--- verilog/stm_sync_idx_gen.sv
`default_nettype none

module stm_sync_idx_gen
  import stm_pkg::*;
#(
  parameter int TickBit = stm_pkg::TickBit
) (
  input  logic                  CLK,
  input  logic                  rst_n,
  input  logic [60:0]           sys_time,
  input  seg_cfg_t              seg_cfg [NumSegment],
  output logic [CycleWidth-1:0] sync_idx [NumSegment]
);

  logic tick_q;
  logic tick;

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      tick_q <= 1'b0;
    end else begin
      tick_q <= sys_time[TickBit];
    end
  end

  assign tick = sys_time[TickBit] && !tick_q;

  for (genvar i = 0; i < NumSegment; i++) begin : gen_seg
    always_ff @(posedge CLK) begin
      if (!rst_n) begin
        sync_idx[i] <= '0;
      end else if (tick) begin
        // also wraps when the cycle was shortened below the current index
        if (sync_idx[i] >= seg_cfg[i].cycle) begin
          sync_idx[i] <= '0;
        end else begin
          sync_idx[i] <= sync_idx[i] + 1'b1;
        end
      end
    end

    assert property (@(posedge CLK) disable iff (!rst_n)
      sync_idx[i] <= seg_cfg[i].cycle);
  end

endmodule

`default_nettype wire

//--- verilog/ec_time_to_sys_time.sv
`default_nettype none

module ec_time_to_sys_time
  import stm_pkg::*;
(
  input  logic        CLK,
  input  logic        rst_n,
  input  logic [63:0] ec_time,
  input  logic        din_valid,
  output logic [55:0] sys_time,
  output logic        dout_valid
);

  logic [63:0] ec_q;
  logic [71:0] prod_q;
  logic [1:0]  valid_q;

  always_ff @(posedge CLK) begin
    ec_q     <= ec_time;
    prod_q   <= 72'(ec_q) * 72'(EcToSysMul);
    // upper product bits are dropped, the system time is only 56 bits wide
    sys_time <= 56'(prod_q >> EcToSysShift);
  end

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      valid_q    <= '0;
      dout_valid <= 1'b0;
    end else begin
      valid_q    <= {valid_q[0], din_valid};
      dout_valid <= valid_q[1];
    end
  end

endmodule

`default_nettype wire

//--- verilog/stm_time_diff.sv
`default_nettype none

module stm_time_diff #(
  parameter int SubLatency = 2
) (
  input  logic               CLK,
  input  logic [60:0]        a,
  input  logic [55:0]        b,
  output logic signed [56:0] diff
);

  logic signed [56:0] pipe [SubLatency];

  // the 57-bit result is taken modulo, sign bit 56 tells which time is ahead
  always_ff @(posedge CLK) begin
    pipe[0] <= 57'(a) - 57'(b);
  end

  for (genvar i = 1; i < SubLatency; i++) begin : gen_stage
    always_ff @(posedge CLK) begin
      pipe[i] <= pipe[i-1];
    end
  end

  assign diff = pipe[SubLatency-1];

endmodule

`default_nettype wire

//--- verilog/stm_swapchain.sv
`default_nettype none

module stm_swapchain
  import stm_pkg::*;
#(
  parameter int SubLatency = 2
) (
  input  logic                  CLK,
  input  logic                  rst_n,
  input  logic [60:0]           sys_time,
  input  stm_settings_t         settings,
  input  seg_cfg_t              seg_cfg [NumSegment],
  input  logic                  update,
  input  logic [CycleWidth-1:0] sync_idx [NumSegment],
  input  logic [3:0]            gpio_in,
  output stm_status_t           status,
  output logic [CycleWidth-1:0] idx [NumSegment]
);

  localparam int LatCntW = $clog2(SubLatency + 1);
  localparam logic [LatCntW-1:0] LatLast = LatCntW'(SubLatency - 1);

  typedef enum logic [1:0] {
    WAIT_START,
    FINITE_LOOP,
    INFINITE_LOOP
  } state_t;

  typedef enum logic {
    IDX_MODE_SYNC_IDX,
    IDX_MODE_TIC
  } idx_mode_t;

  state_t                state;
  idx_mode_t             idx_mode;
  transition_mode_t      mode;
  logic                  segment;
  logic                  req_segment;
  logic                  stop;
  logic                  ext_mode;
  logic [15:0]           rep;
  logic [15:0]           loop_cnt;
  logic [CycleWidth-1:0] idx_old [NumSegment];
  logic [CycleWidth-1:0] tic_idx [NumSegment];
  logic                  idx_changed [NumSegment];
  logic                  wrapped [NumSegment];
  logic                  conv_valid;
  logic                  conv_done;
  logic                  wait_transition;
  logic [LatCntW-1:0]    lat_cnt;
  logic [55:0]           transition_time;
  logic signed [56:0]    time_diff;
  logic                  start_evt;

  ec_time_to_sys_time i_ec_time_to_sys_time (
    .CLK       (CLK),
    .rst_n     (rst_n),
    .ec_time   (settings.transition_value),
    .din_valid (conv_valid),
    .sys_time  (transition_time),
    .dout_valid(conv_done)
  );

  stm_time_diff #(
    .SubLatency(SubLatency)
  ) i_stm_time_diff (
    .CLK (CLK),
    .a   (sys_time),
    .b   (transition_time),
    .diff(time_diff)
  );

  for (genvar i = 0; i < NumSegment; i++) begin : gen_idx
    always_ff @(posedge CLK) begin
      if (!rst_n) begin
        idx_old[i] <= '0;
      end else begin
        idx_old[i] <= sync_idx[i];
      end
    end
    assign idx_changed[i] = idx_old[i] != sync_idx[i];
    assign wrapped[i]     = idx_changed[i] && (sync_idx[i] == '0);
    assign idx[i]         = (idx_mode == IDX_MODE_SYNC_IDX) ? idx_old[i] : tic_idx[i];
  end

  // start event of the pending transition
  always_comb begin
    case (mode)
      TRANSITION_MODE_SYNC_IDX: start_evt = wrapped[req_segment];
      TRANSITION_MODE_SYS_TIME: start_evt = !wait_transition && (lat_cnt == LatLast) &&
                                            !time_diff[56];
      TRANSITION_MODE_GPIO:     start_evt = idx_changed[req_segment] &&
                                            gpio_in[settings.transition_value[1:0]];
      default:                  start_evt = 1'b0;
    endcase
  end

  // ==============================
  // segment state machine
  // ==============================
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      state           <= INFINITE_LOOP;
      idx_mode        <= IDX_MODE_SYNC_IDX;
      mode            <= TRANSITION_MODE_SYNC_IDX;
      segment         <= 1'b0;
      req_segment     <= 1'b0;
      stop            <= 1'b0;
      ext_mode        <= 1'b0;
      rep             <= '0;
      loop_cnt        <= '0;
      conv_valid      <= 1'b0;
      wait_transition <= 1'b0;
      lat_cnt         <= '0;
      tic_idx         <= '{default: '0};
    end else begin
      conv_valid <= 1'b0;
      if (update) begin
        stop <= 1'b0;
        if (seg_cfg[settings.req_segment].rep == RepInfinite) begin
          segment  <= settings.req_segment;
          idx_mode <= IDX_MODE_SYNC_IDX;
          ext_mode <= settings.transition_mode == TRANSITION_MODE_EXT;
          state    <= INFINITE_LOOP;
        end else begin
          rep             <= seg_cfg[settings.req_segment].rep;
          req_segment     <= settings.req_segment;
          mode            <= settings.transition_mode;
          conv_valid      <= settings.transition_mode == TRANSITION_MODE_SYS_TIME;
          wait_transition <= 1'b1;
          lat_cnt         <= '0;
          state           <= WAIT_START;
        end
      end else begin
        case (state)
          WAIT_START: begin
            if (conv_done) begin
              wait_transition <= 1'b0;
            end
            // time_diff is valid SubLatency cycles after the conversion
            if (!wait_transition && (lat_cnt != LatLast)) begin
              lat_cnt <= lat_cnt + 1'b1;
            end
            if (start_evt) begin
              loop_cnt             <= '0;
              segment              <= req_segment;
              idx_mode             <= (mode == TRANSITION_MODE_SYNC_IDX) ?
                                      IDX_MODE_SYNC_IDX : IDX_MODE_TIC;
              tic_idx[req_segment] <= '0;
              state                <= FINITE_LOOP;
            end
          end
          INFINITE_LOOP: begin
            if (ext_mode && wrapped[segment]) begin
              segment <= ~segment;
            end
          end
          FINITE_LOOP: begin
            if (idx_mode == IDX_MODE_SYNC_IDX) begin
              if (wrapped[segment]) begin
                if (loop_cnt == rep) begin
                  stop <= 1'b1;
                end else begin
                  loop_cnt <= loop_cnt + 1'b1;
                end
              end
            end else if (idx_changed[segment]) begin
              if (tic_idx[segment] >= seg_cfg[segment].cycle) begin
                tic_idx[segment] <= '0;
                if (loop_cnt == rep) begin
                  stop <= 1'b1;
                end else begin
                  loop_cnt <= loop_cnt + 1'b1;
                end
              end else begin
                tic_idx[segment] <= tic_idx[segment] + 1'b1;
              end
            end
          end
          default: state <= INFINITE_LOOP;
        endcase
      end
    end
  end

  assign status.stop    = stop;
  assign status.segment = segment;

  assert property (@(posedge CLK) disable iff (!rst_n) stop |-> (state == FINITE_LOOP));
  assert property (@(posedge CLK) disable iff (!rst_n) conv_valid |=> !conv_valid);

endmodule

`default_nettype wire

//--- verilog/stm_top.sv
`default_nettype none

module stm_top
  import stm_pkg::*;
#(
  parameter int SubLatency = 2,
  parameter int TickBit    = stm_pkg::TickBit
) (
  input  logic                  CLK,
  input  logic                  rst_n,
  input  logic                  cyc,
  input  logic                  stb,
  input  logic                  we,
  input  wb_reg_addr_t          adr,
  input  logic [31:0]           dat_w,
  output logic [31:0]           dat_r,
  output logic                  ack,
  input  logic [60:0]           sys_time,
  input  logic [3:0]            gpio_in,
  output stm_status_t           status,
  output logic [CycleWidth-1:0] idx [NumSegment]
);

  stm_settings_t         settings;
  seg_cfg_t              seg_cfg [NumSegment];
  logic                  update;
  logic [CycleWidth-1:0] sync_idx [NumSegment];

  stm_settings_wb i_stm_settings_wb (
    .CLK     (CLK),
    .rst_n   (rst_n),
    .cyc     (cyc),
    .stb     (stb),
    .we      (we),
    .adr     (adr),
    .dat_w   (dat_w),
    .dat_r   (dat_r),
    .ack     (ack),
    .status  (status),
    .settings(settings),
    .seg_cfg (seg_cfg),
    .update  (update)
  );

  stm_sync_idx_gen #(
    .TickBit(TickBit)
  ) i_stm_sync_idx_gen (
    .CLK     (CLK),
    .rst_n   (rst_n),
    .sys_time(sys_time),
    .seg_cfg (seg_cfg),
    .sync_idx(sync_idx)
  );

  stm_swapchain #(
    .SubLatency(SubLatency)
  ) i_stm_swapchain (
    .CLK     (CLK),
    .rst_n   (rst_n),
    .sys_time(sys_time),
    .settings(settings),
    .seg_cfg (seg_cfg),
    .update  (update),
    .sync_idx(sync_idx),
    .gpio_in (gpio_in),
    .status  (status),
    .idx     (idx)
  );

endmodule

`default_nettype wire

//--- bench/tb_stm_top.sv
`default_nettype none

module tb_stm_top
  import stm_pkg::*;
;

  localparam int SubLatency = 2;
  // sys_time advances by one per clock, so one index tick every 2**(TickBit+1) clocks
  localparam int TickPeriod = 2 ** (TickBit + 1);
  localparam int TimeoutCycles = 30000;

  logic                  CLK;
  logic                  rst_n;
  logic                  cyc;
  logic                  stb;
  logic                  we;
  wb_reg_addr_t          adr;
  logic [31:0]           dat_w;
  logic [31:0]           dat_r;
  logic                  ack;
  logic [60:0]           sys_time;
  logic [3:0]            gpio_in;
  stm_status_t           status;
  logic [CycleWidth-1:0] idx [NumSegment];

  seg_cfg_t    cfg [NumSegment];
  int unsigned cycle_cnt;

  stm_top #(
    .SubLatency(SubLatency),
    .TickBit   (TickBit)
  ) i_dut (
    .CLK     (CLK),
    .rst_n   (rst_n),
    .cyc     (cyc),
    .stb     (stb),
    .we      (we),
    .adr     (adr),
    .dat_w   (dat_w),
    .dat_r   (dat_r),
    .ack     (ack),
    .sys_time(sys_time),
    .gpio_in (gpio_in),
    .status  (status),
    .idx     (idx)
  );

  always #20 CLK = ~CLK;

  always @(posedge CLK) begin
    sys_time <= sys_time + 1'b1;
  end

  always @(posedge CLK) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TimeoutCycles) begin
      fail_run("timeout, the tests did not finish within the cycle limit");
    end
  end

  // ==============================
  // helpers
  // ==============================
  task automatic fail_run(input string what);
    $display("%s", what);
    $display("RESULT: FAIL");
    $fatal(1, "simulation stopped at the first error");
  endtask

  function automatic stm_status_t status_value(input logic stop, input logic segment);
    stm_status_t s;
    s.stop    = stop;
    s.segment = segment;
    return s;
  endfunction

  function automatic logic [31:0] ctrl_word(input logic seg, input transition_mode_t mode);
    return {16'h0, mode, 7'h0, seg};
  endfunction

  // an index counts up to its cycle and then starts again at zero
  function automatic logic [CycleWidth-1:0] next_idx(input logic [CycleWidth-1:0] prev,
                                                     input logic [CycleWidth-1:0] cycle);
    return (prev == cycle) ? '0 : prev + 1'b1;
  endfunction

  task automatic check_status(input string name, input stm_status_t exp,
                              input stm_status_t act);
    if (exp !== act) begin
      fail_run($sformatf("Error: %s expected %b actual %b", name, exp, act));
    end
  endtask

  task automatic check_idx(input string name, input logic [CycleWidth-1:0] exp,
                           input logic [CycleWidth-1:0] act);
    if (exp !== act) begin
      fail_run($sformatf("Error: %s expected %0d actual %0d", name, exp, act));
    end
  endtask

  task automatic check_seg_cfg(input string name, input seg_cfg_t exp, input seg_cfg_t act);
    if (exp !== act) begin
      fail_run($sformatf("Error: %s expected %h actual %h", name, exp, act));
    end
  endtask

  task automatic wb_write(input wb_reg_addr_t addr, input logic [31:0] data);
    @(posedge CLK);
    cyc   <= 1'b1;
    stb   <= 1'b1;
    we    <= 1'b1;
    adr   <= addr;
    dat_w <= data;
    do @(negedge CLK); while (!ack);
    @(posedge CLK);
    cyc <= 1'b0;
    stb <= 1'b0;
    we  <= 1'b0;
  endtask

  task automatic wb_read(input wb_reg_addr_t addr, output logic [31:0] data);
    @(posedge CLK);
    cyc <= 1'b1;
    stb <= 1'b1;
    we  <= 1'b0;
    adr <= addr;
    do @(negedge CLK); while (!ack);
    data = dat_r;
    @(posedge CLK);
    cyc <= 1'b0;
    stb <= 1'b0;
  endtask

  task automatic wait_idx_change(input int seg, input logic [CycleWidth-1:0] prev,
                                 output logic [CycleWidth-1:0] now);
    do @(negedge CLK); while (idx[seg] == prev);
    now = idx[seg];
  endtask

  // ==============================
  // tests
  // ==============================
  task automatic reg_readback();
    logic [31:0] rd_cycle;
    logic [31:0] rd_rep;
    seg_cfg_t    got;
    for (int s = 0; s < NumSegment; s++) begin
      cfg[s].cycle = CycleWidth'(3 + $urandom % 8);
      cfg[s].rep   = 16'(1 + $urandom % 3);
      wb_write((s == 0) ? REG_CYCLE0 : REG_CYCLE1, 32'(cfg[s].cycle));
      wb_write((s == 0) ? REG_REP0 : REG_REP1, 32'(cfg[s].rep));
    end
    for (int s = 0; s < NumSegment; s++) begin
      wb_read((s == 0) ? REG_CYCLE0 : REG_CYCLE1, rd_cycle);
      wb_read((s == 0) ? REG_REP0 : REG_REP1, rd_rep);
      got.cycle = rd_cycle[CycleWidth-1:0];
      got.rep   = rd_rep[15:0];
      check_seg_cfg("reg_readback", cfg[s], got);
    end
  endtask

  task automatic infinite_loop_switch();
    logic [CycleWidth-1:0] prev;
    logic [CycleWidth-1:0] cur;
    wb_write(REG_REP1, 32'(RepInfinite));
    wb_write(REG_CTRL, ctrl_word(1'b1, TRANSITION_MODE_SYNC_IDX));
    @(negedge CLK);
    check_status("infinite_loop_switch", status_value(1'b0, 1'b1), status);
    prev = idx[1];
    repeat (2 * (cfg[1].cycle + 1)) begin
      wait_idx_change(1, prev, cur);
      check_idx("infinite_loop_switch", next_idx(prev, cfg[1].cycle), cur);
      check_status("infinite_loop_switch", status_value(1'b0, 1'b1), status);
      prev = cur;
    end
  endtask

  task automatic sync_idx_transition();
    logic [CycleWidth-1:0] prev;
    logic [CycleWidth-1:0] cur;
    logic                  wrap;
    logic                  switched;
    int                    wraps;
    wb_write(REG_CTRL, ctrl_word(1'b0, TRANSITION_MODE_SYNC_IDX));
    @(negedge CLK);
    check_status("sync_idx_transition", status_value(1'b0, 1'b1), status);
    prev     = idx[0];
    switched = 1'b0;
    // the segment may only change in the sample that shows the wrap of segment 0
    while (!switched) begin
      @(negedge CLK);
      cur  = idx[0];
      wrap = (cur != prev) && (cur == '0);
      check_status("sync_idx_transition", status_value(1'b0, !wrap), status);
      switched = wrap;
      prev     = cur;
    end
    wraps = 0;
    while (wraps < cfg[0].rep + 2) begin
      @(negedge CLK);
      cur = idx[0];
      if (cur != prev) begin
        check_idx("sync_idx_transition", next_idx(prev, cfg[0].cycle), cur);
        if (cur == '0) begin
          wraps++;
        end
      end
      check_status("sync_idx_transition", status_value(wraps >= cfg[0].rep + 1, 1'b0),
                   status);
      prev = cur;
    end
  endtask

  task automatic sys_time_transition();
    logic [63:0]           tval;
    logic [63:0]           target;
    logic [CycleWidth-1:0] prev;
    logic [CycleWidth-1:0] cur;
    logic                  switched;
    wb_write(REG_REP1, 32'(cfg[1].rep));
    tval   = 64'(sys_time / 4) + 64'd100;
    target = tval * 4;
    wb_write(REG_TVAL_LO, tval[31:0]);
    wb_write(REG_TVAL_HI, tval[63:32]);
    wb_write(REG_CTRL, ctrl_word(1'b1, TRANSITION_MODE_SYS_TIME));
    switched = 1'b0;
    while (!switched) begin
      @(negedge CLK);
      if (status.segment) begin
        switched = 1'b1;
        if (64'(sys_time) < target) begin
          fail_run("sys_time_transition: segment switched before the target time");
        end
        if (64'(sys_time) > target + 16) begin
          fail_run("sys_time_transition: segment switched too late after the target time");
        end
        check_status("sys_time_transition", status_value(1'b0, 1'b1), status);
        check_idx("sys_time_transition", '0, idx[1]);
      end else begin
        check_status("sys_time_transition", status_value(1'b0, 1'b0), status);
      end
    end
    prev = idx[1];
    repeat (cfg[1].cycle + 2) begin
      wait_idx_change(1, prev, cur);
      check_idx("sys_time_transition", next_idx(prev, cfg[1].cycle), cur);
      prev = cur;
    end
  endtask

  task automatic gpio_transition();
    logic [CycleWidth-1:0] cur;
    int                    waited;
    // bit 0 is high but bit 2 is the one selected
    @(posedge CLK);
    gpio_in <= 4'b0001;
    wb_write(REG_TVAL_LO, 32'd2);
    wb_write(REG_TVAL_HI, 32'd0);
    wb_write(REG_CTRL, ctrl_word(1'b0, TRANSITION_MODE_GPIO));
    repeat (4 * TickPeriod) begin
      @(negedge CLK);
      check_status("gpio_transition", status_value(1'b0, 1'b1), status);
    end
    @(posedge CLK);
    gpio_in <= 4'b0101;
    waited = 0;
    do begin
      @(negedge CLK);
      waited++;
    end while (status.segment && (waited <= TickPeriod + 4));
    if (status.segment) begin
      fail_run("gpio_transition: segment did not switch at the next index tick");
    end
    check_status("gpio_transition", status_value(1'b0, 1'b0), status);
    check_idx("gpio_transition", '0, idx[0]);
    wait_idx_change(0, '0, cur);
    check_idx("gpio_transition", 13'd1, cur);
  endtask

  task automatic ext_alternation();
    logic [CycleWidth-1:0] prev_i [NumSegment];
    logic                  prev_seg;
    logic                  wrap;
    int                    toggles;
    wb_write(REG_REP1, 32'(RepInfinite));
    wb_write(REG_CTRL, ctrl_word(1'b1, TRANSITION_MODE_EXT));
    @(negedge CLK);
    check_status("ext_alternation", status_value(1'b0, 1'b1), status);
    prev_seg  = status.segment;
    prev_i[0] = idx[0];
    prev_i[1] = idx[1];
    toggles   = 0;
    while (toggles < 4) begin
      @(negedge CLK);
      wrap = (idx[prev_seg] != prev_i[prev_seg]) && (idx[prev_seg] == '0);
      check_status("ext_alternation", status_value(1'b0, wrap ? !prev_seg : prev_seg),
                   status);
      if (wrap) begin
        toggles++;
      end
      prev_seg  = status.segment;
      prev_i[0] = idx[0];
      prev_i[1] = idx[1];
    end
  endtask

  initial begin
    void'($urandom(78));
    CLK       = 1'b0;
    rst_n     = 1'b0;
    cyc       = 1'b0;
    stb       = 1'b0;
    we        = 1'b0;
    adr       = REG_CTRL;
    dat_w     = '0;
    sys_time  = '0;
    gpio_in   = '0;
    cycle_cnt = 0;
    repeat (4) @(posedge CLK);
    rst_n <= 1'b1;
    @(negedge CLK);
    if (ack) begin
      fail_run("ack is high after reset");
    end
    check_status("reset", status_value(1'b0, 1'b0), status);

    reg_readback();
    infinite_loop_switch();
    sync_idx_transition();
    sys_time_transition();
    gpio_transition();
    ext_alternation();

    $display("RESULT: PASS");
    $finish;
  end

endmodule

`default_nettype wire

//--- vlog.f
verilog/stm_pkg.sv
verilog/stm_settings_wb.sv
verilog/stm_sync_idx_gen.sv
verilog/ec_time_to_sys_time.sv
verilog/stm_time_diff.sv
verilog/stm_swapchain.sv
verilog/stm_top.sv
bench/tb_stm_top.sv

//--- Bender.yml
package:
  name: stm_swapchain

sources:
  - files:
      - verilog/stm_pkg.sv
      - verilog/stm_settings_wb.sv
      - verilog/stm_sync_idx_gen.sv
      - verilog/ec_time_to_sys_time.sv
      - verilog/stm_time_diff.sv
      - verilog/stm_swapchain.sv
      - verilog/stm_top.sv
  - target: test
    files:
      - bench/tb_stm_top.sv
